// File: src.f
+incdir+hdl
hdl/loader_pkg.sv
hdl/act_streamer.sv
hdl/weight_streamer.sv
hdl/core_pool.sv
hdl/channel_sequencer.sv
hdl/act_weight_loader.sv
verification/tb_act_weight_loader.sv

// File: run.sh
#!/bin/sh
# build and run the loader testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f src.f \
        --top-module tb_act_weight_loader -o sim_loader; then
    echo "build failed"
    exit 1
fi

./obj_dir/sim_loader > sim.log 2>&1
sim_status=$?
cat sim.log

if grep -q "Test failed" sim.log; then
    echo "simulation reported failure"
    exit 1
fi

if [ "$sim_status" -ne 0 ]; then
    echo "simulator exited with status $sim_status"
    exit 1
fi

exit 0

// File: verification/tb_act_weight_loader.sv
`include "loader_macros.svh"

module tb_act_weight_loader import loader_pkg::*; ();

    logic                      clk;
    logic                      resetn;
    logic                      start;
    layer_cfg_t                cfg;
    logic                      done;
    mem_rd_t                   act_rd;
    mem_rd_t                   weight_rd;
    logic [`LD_DATA_W-1:0]     act_rdata = '0;
    logic [`LD_DATA_W-1:0]     weight_rdata = '0;
    row_wr_t                   act_wr;
    row_wr_t                   weight_wr;
    logic [`LD_NUM_DENSE-1:0]  dense_done = '0;
    logic [`LD_NUM_SPARSE-1:0] sparse_done = '0;
    logic [`LD_NUM_DENSE-1:0]  dense_start;
    logic [`LD_NUM_SPARSE-1:0] sparse_start;

    logic [`LD_DATA_W-1:0] act_mem [0:1023];
    logic [`LD_DATA_W-1:0] wgt_mem [0:1023];
    logic [15:0]           lfsr;
    int                    delay_tab [0:255];
    int                    delay_ptr = 0;
    int                    core_cnt [0:11];
    logic                  act_req_q = 1'b0;
    logic                  wgt_req_q = 1'b0;
    logic [`LD_ADDR_IN-1:0] act_addr_q;
    logic [`LD_ADDR_IN-1:0] wgt_addr_q;

    // monitor state
    int   rd_ch, rd_cnt;      // activation reads
    int   wrd_ch, wrd_cnt;    // weight reads
    int   aw_ch, aw_cnt;      // activation row writes
    int   ww_ch, ww_cnt;      // weight row writes
    int   st_ch;
    int   res_ch;
    int   exp_core [0:1023];
    bit   exp_sp [0:1023];
    bit   arm;
    bit   pending;
    bit   running = 0;
    bit   blocked_seen = 0;
    int   done_cnt = 0;
    int   cycles = 0;
    int   cycle_limit = 1000;
    logic [`LD_NUM_DENSE-1:0]  busy_d = '0;
    logic [`LD_NUM_SPARSE-1:0] busy_s = '0;

    act_weight_loader i_dut (
        .clk(clk), .resetn(resetn), .start(start), .cfg(cfg), .done(done),
        .act_rd(act_rd), .act_rdata(act_rdata), .weight_rd(weight_rd),
        .weight_rdata(weight_rdata), .act_wr(act_wr), .weight_wr(weight_wr),
        .dense_done(dense_done), .sparse_done(sparse_done),
        .dense_start(dense_start), .sparse_start(sparse_start)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // --------------------------------------------------
    // helpers
    // --------------------------------------------------
    // fibonacci lfsr on taps 16 14 13 11 stepped once per bit
    function automatic int lfsr_bits(int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
            v = (v << 1) | lfsr[0];
        end
        return v;
    endfunction

    function automatic int padded_w();
        return cfg.img_w + cfg.k - 1;
    endfunction

    function automatic int plane_size();
        return (cfg.img_h + cfg.k - 1) * (cfg.img_w + cfg.k - 1);
    endfunction

    // verdict from the first padded row of channel c
    function automatic bit ref_sparse(int c);
        int zeros;
        zeros = 0;
        for (int i = 0; i < padded_w(); i++) begin
            if (act_mem[c * plane_size() + i] == '0) zeros++;
        end
        return 2 * zeros >= padded_w();
    endfunction

    function automatic int ref_act(int c, int i);
        return act_mem[c * plane_size() + i];
    endfunction

    // filter-major address of row word i of channel c
    function automatic int wgt_addr(int c, int i);
        int kk;
        kk = cfg.k * cfg.k;
        return (i / kk) * kk * cfg.total_ic + c * kk + i % kk;
    endfunction

    function automatic int ref_wgt(int c, int i);
        return wgt_mem[wgt_addr(c, i)];
    endfunction

    function automatic int lowest_free(logic [7:0] free);
        for (int i = 0; i < 8; i++) begin
            if (free[i]) return i;
        end
        return -1;
    endfunction

    task automatic fail_run(string why);
        $display("%s (time %0t)", why, $time);
        $display("Test failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(string name, int got, int exp);
        if (got != exp) begin
            $display("** Error at %0t: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
            fail_run("value mismatch");
        end
    endtask

    // --------------------------------------------------
    // memory and core models
    // --------------------------------------------------
    always @(posedge clk) begin
        act_req_q  <= act_rd.en;
        act_addr_q <= act_rd.addr;
        wgt_req_q  <= weight_rd.en;
        wgt_addr_q <= weight_rd.addr;
    end

    always @(negedge clk) begin
        logic [11:0] st;
        logic [11:0] dv;
        st = {sparse_start, dense_start};
        dv = '0;
        if (act_req_q) act_rdata = act_mem[act_addr_q];   // one cycle after the read
        if (wgt_req_q) weight_rdata = wgt_mem[wgt_addr_q];
        for (int i = 0; i < 12; i++) begin
            if (st[i]) begin
                core_cnt[i] = delay_tab[delay_ptr];
                delay_ptr = (delay_ptr + 1) % 256;
            end else if (core_cnt[i] > 0) begin
                core_cnt[i]--;
                if (core_cnt[i] == 0) dv[i] = 1'b1;
            end
        end
        dense_done  = dv[7:0];
        sparse_done = dv[11:8];
    end

    // --------------------------------------------------
    // comparing process
    // --------------------------------------------------
    always @(posedge clk) begin
        int free_idx;
        int got;
        int code;
        if (start) begin
            rd_ch = 0;
            rd_cnt = 0;
            wrd_ch = 0;
            wrd_cnt = 0;
            aw_ch = 0;
            aw_cnt = 0;
            ww_ch = 0;
            ww_cnt = 0;
            st_ch = 0;
            arm = 0;
            pending = 0;
            done_cnt = 0;
            cycles = 0;
            running = 1;
            cycle_limit = 2 * (cfg.total_ic * (padded_w() + plane_size()
                          + cfg.k * cfg.k * cfg.oc + 13 + 60)) + 400;
        end else begin
            if (running) cycles++;
            if (cycles > cycle_limit) fail_run("timeout, loader never finished the layer");
            // nothing moves before the first layer starts
            if (!running) begin
                check_value("done before start", done, 0);
                check_value("act_wr.en before start", act_wr.en, 0);
                check_value("weight_wr.en before start", weight_wr.en, 0);
            end
            busy_d &= ~dense_done;
            busy_s &= ~sparse_done;
            // reservation lands two cycles after the last probe read
            if (pending) begin
                free_idx = exp_sp[res_ch] ? lowest_free({4'b0, ~busy_s})
                                          : lowest_free(~busy_d);
                if (free_idx < 0) begin
                    blocked_seen = 1;
                    check_value("act_wr.en while pool full", act_wr.en, 0);
                    check_value("weight_wr.en while pool full", weight_wr.en, 0);
                end else begin
                    exp_core[res_ch] = free_idx;
                    if (exp_sp[res_ch]) busy_s[free_idx] = 1'b1;
                    else busy_d[free_idx] = 1'b1;
                    pending = 0;
                end
            end
            if (arm) begin
                pending = 1;
                arm = 0;
            end
            if (act_rd.en) begin
                check_value("act_rd.addr", act_rd.addr, rd_ch * plane_size()
                            + (rd_cnt < padded_w() ? rd_cnt : rd_cnt - padded_w()));
                rd_cnt++;
                if (rd_cnt == padded_w()) begin
                    arm = 1;
                    res_ch = rd_ch;
                    exp_sp[rd_ch] = ref_sparse(rd_ch);
                end
                if (rd_cnt == padded_w() + plane_size()) begin
                    rd_ch++;
                    rd_cnt = 0;
                end
            end
            if (weight_rd.en) begin
                check_value("weight_rd.addr", weight_rd.addr, wgt_addr(wrd_ch, wrd_cnt));
                wrd_cnt++;
                if (wrd_cnt == cfg.k * cfg.k * cfg.oc) begin
                    wrd_ch++;
                    wrd_cnt = 0;
                end
            end
            if (act_wr.en) begin
                check_value("act_wr.addr", act_wr.addr, aw_cnt);
                check_value("act_wr.data", act_wr.data, ref_act(aw_ch, aw_cnt));
                aw_cnt++;
                if (aw_cnt == plane_size()) begin
                    aw_ch++;
                    aw_cnt = 0;
                end
            end
            if (weight_wr.en) begin
                check_value("weight_wr.addr", weight_wr.addr, ww_cnt);
                check_value("weight_wr.data", weight_wr.data, ref_wgt(ww_ch, ww_cnt));
                ww_cnt++;
                if (ww_cnt == cfg.k * cfg.k * cfg.oc) begin
                    ww_ch++;
                    ww_cnt = 0;
                end
            end
            if ({sparse_start, dense_start} != '0) begin
                check_value("start inside layer", st_ch < cfg.total_ic, 1);
                check_value("start bit count", $countones({sparse_start, dense_start}), 1);
                got = 0;
                for (int i = 0; i < 12; i++) begin
                    if ({sparse_start, dense_start} >> i & 12'd1) got = i;
                end
                code = exp_sp[st_ch] ? 8 + exp_core[st_ch] : exp_core[st_ch];
                check_value("start core", got, code);   // sparse cores map to 8..11
                st_ch++;
            end
            if (done) begin
                check_value("starts before done", st_ch, cfg.total_ic);
                check_value("done pulses", done_cnt, 0);
                done_cnt++;
            end
        end
    end

    task automatic run_layer(int ic, int oc, int h, int w, int k);
        @(negedge clk);
        cfg.total_ic = ic;
        cfg.oc       = oc;
        cfg.img_h    = h;
        cfg.img_w    = w;
        cfg.k        = k;
        start        = 1'b1;
        @(negedge clk);
        start = 1'b0;
        while (done_cnt == 0) @(negedge clk);
        repeat (150) @(negedge clk);   // room for a stray second done
        check_value("done pulses after layer", done_cnt, 1);
    endtask

    // --------------------------------------------------
    // main sequence
    // --------------------------------------------------
    initial begin
        resetn = 1'b0;
        start  = 1'b0;
        cfg    = '0;
        lfsr   = 16'd74;
        for (int i = 0; i < 12; i++) core_cnt[i] = 0;
        for (int a = 0; a < 1024; a++) begin
            act_mem[a] = lfsr_bits(8);
            if (lfsr_bits(4) % 3 == 0) act_mem[a] = '0;   // roughly a third zero
            wgt_mem[a] = lfsr_bits(8);
        end
        for (int i = 0; i < 256; i++) delay_tab[i] = 20 + lfsr_bits(6) % 41;
        // K=3 layer with 6x6 padded planes
        // channels 1 and 3 start with a zero row
        for (int i = 0; i < 6; i++) begin
            act_mem[36 + i]  = '0;
            act_mem[108 + i] = '0;
        end
        repeat (8) @(posedge clk);
        @(negedge clk);
        resetn = 1'b1;
        check_value("done after reset", done, 0);
        check_value("dense_start after reset", dense_start, 0);
        check_value("sparse_start after reset", sparse_start, 0);
        check_value("act_wr.en after reset", act_wr.en, 0);
        check_value("weight_wr.en after reset", weight_wr.en, 0);
        check_value("act_rd.en after reset", act_rd.en, 0);
        check_value("weight_rd.en after reset", weight_rd.en, 0);

        run_layer(6, 2, 4, 4, 3);

        // twelve sparse 1x1 channels back to back fill the sparse pool
        for (int c = 0; c < 16; c++) act_mem[c] = (c < 12) ? 8'h00 : (act_mem[c] | 8'h01);
        run_layer(16, 1, 1, 1, 1);

        if (!blocked_seen) begin
            fail_run("sparse pool never filled up, back-pressure was not exercised");
        end else begin
            $display("Test completed successfully");
            $finish;
        end
    end

endmodule

// File: hdl/act_weight_loader.sv
`include "loader_macros.svh"

module act_weight_loader import loader_pkg::*; (
    input  logic                      clk,
    input  logic                      resetn,
    input  logic                      start,
    input  layer_cfg_t                cfg,
    output logic                      done,
    output mem_rd_t                   act_rd,
    input  logic [`LD_DATA_W-1:0]     act_rdata,
    output mem_rd_t                   weight_rd,
    input  logic [`LD_DATA_W-1:0]     weight_rdata,
    output row_wr_t                   act_wr,
    output row_wr_t                   weight_wr,
    input  logic [`LD_NUM_DENSE-1:0]  dense_done,
    input  logic [`LD_NUM_SPARSE-1:0] sparse_done,
    output logic [`LD_NUM_DENSE-1:0]  dense_start,
    output logic [`LD_NUM_SPARSE-1:0] sparse_start
);

    logic [`LD_IC_W-1:0] ic_idx;
    logic                probe_go;
    logic                load_go;
    logic                probe_done;
    logic                is_sparse;
    logic                act_load_done;
    logic                wgt_load_done;
    logic                core_req;
    logic                pool_sparse;
    logic                grant;
    logic                launch;

    // --------------------------------------------------
    // per-channel job control
    // --------------------------------------------------
    channel_sequencer i_seq (
        .clk(clk), .resetn(resetn), .start(start), .cfg(cfg), .ic_idx(ic_idx),
        .probe_go(probe_go), .load_go(load_go), .core_req(core_req),
        .pool_sparse(pool_sparse), .launch(launch), .done(done),
        .probe_done(probe_done), .is_sparse(is_sparse), .load_done_act(act_load_done),
        .load_done_wgt(wgt_load_done), .grant(grant)
    );

    // --------------------------------------------------
    // streams and core pools
    // --------------------------------------------------
    act_streamer i_act (
        .clk(clk), .resetn(resetn), .cfg(cfg), .ic_idx(ic_idx), .probe_go(probe_go),
        .load_go(load_go), .act_rd(act_rd), .act_wr(act_wr), .probe_done(probe_done),
        .is_sparse(is_sparse), .load_done(act_load_done), .act_rdata(act_rdata)
    );

    weight_streamer i_wgt (
        .clk(clk), .resetn(resetn), .cfg(cfg), .ic_idx(ic_idx), .load_go(load_go),
        .weight_rd(weight_rd), .weight_wr(weight_wr), .load_done(wgt_load_done),
        .weight_rdata(weight_rdata)
    );

    core_pool i_pool (
        .clk(clk), .resetn(resetn), .core_req(core_req), .pool_sparse(pool_sparse),
        .launch(launch), .grant(grant), .dense_done(dense_done),
        .sparse_done(sparse_done), .dense_start(dense_start), .sparse_start(sparse_start)
    );

endmodule

// File: hdl/channel_sequencer.sv
`include "loader_macros.svh"

module channel_sequencer import loader_pkg::*; (
    input  logic                clk,
    input  logic                resetn,
    input  logic                start,
    input  layer_cfg_t          cfg,
    output logic [`LD_IC_W-1:0] ic_idx,
    output logic                probe_go,
    output logic                load_go,
    output logic                core_req,
    output logic                pool_sparse,
    output logic                launch,
    output logic                done,
    input  logic                probe_done,
    input  logic                is_sparse,
    input  logic                load_done_act,
    input  logic                load_done_wgt,
    input  logic                grant
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_PROBE,
        S_RESERVE,
        S_LOAD,
        S_LAUNCH,
        S_FINISH
    } state_t;

    state_t state;
    logic   act_seen;
    logic   wgt_seen;
    logic   act_ok;
    logic   wgt_ok;
    logic   last_ch;

    // the two streams finish in either order
    assign act_ok   = act_seen || load_done_act;
    assign wgt_ok   = wgt_seen || load_done_wgt;
    assign last_ch  = (ic_idx == cfg.total_ic - 1'b1);
    assign core_req = (state == S_RESERVE);

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            state       <= S_IDLE;
            ic_idx      <= '0;
            probe_go    <= 1'b0;
            load_go     <= 1'b0;
            launch      <= 1'b0;
            done        <= 1'b0;
            pool_sparse <= 1'b0;
            act_seen    <= 1'b0;
            wgt_seen    <= 1'b0;
        end else begin
            probe_go <= 1'b0;   // all handshake outputs are single-cycle pulses
            load_go  <= 1'b0;
            launch   <= 1'b0;
            done     <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (start) begin
                        ic_idx   <= '0;
                        probe_go <= 1'b1;
                        state    <= S_PROBE;
                    end
                end
                S_PROBE: begin
                    if (probe_done) begin
                        pool_sparse <= is_sparse;   // verdict picks the pool
                        state       <= S_RESERVE;
                    end
                end
                S_RESERVE: begin
                    if (grant) begin
                        load_go  <= 1'b1;
                        act_seen <= 1'b0;
                        wgt_seen <= 1'b0;
                        state    <= S_LOAD;
                    end
                end
                S_LOAD: begin
                    act_seen <= act_ok;
                    wgt_seen <= wgt_ok;
                    if (act_ok && wgt_ok) begin
                        launch <= 1'b1;
                        state  <= S_LAUNCH;
                    end
                end
                S_LAUNCH: begin
                    if (last_ch) begin
                        state <= S_FINISH;
                    end else begin
                        ic_idx   <= ic_idx + 1'b1;
                        probe_go <= 1'b1;
                        state    <= S_PROBE;
                    end
                end
                S_FINISH: begin
                    done  <= 1'b1;   // lands after the last start bit
                    state <= S_IDLE;
                end
                default: state <= S_IDLE;
            endcase
        end
    end

endmodule

// File: hdl/core_pool.sv
`include "loader_macros.svh"

module core_pool import loader_pkg::*; (
    input  logic                      clk,
    input  logic                      resetn,
    input  logic                      core_req,
    input  logic                      pool_sparse,
    input  logic                      launch,
    output logic                      grant,
    input  logic [`LD_NUM_DENSE-1:0]  dense_done,
    input  logic [`LD_NUM_SPARSE-1:0] sparse_done,
    output logic [`LD_NUM_DENSE-1:0]  dense_start,
    output logic [`LD_NUM_SPARSE-1:0] sparse_start
);

    localparam int IDX_W = $clog2(`LD_NUM_DENSE);   // sized for the larger pool

    logic [`LD_NUM_DENSE-1:0]  busy_d;
    logic [`LD_NUM_SPARSE-1:0] busy_s;
    logic [`LD_NUM_DENSE-1:0]  free_d;
    logic [`LD_NUM_DENSE-1:0]  free_s_ext;
    logic [IDX_W:0]            pick;       // {found, index}
    logic                      take;
    logic [`LD_NUM_DENSE-1:0]  pick_oh;
    logic [`LD_NUM_DENSE-1:0]  res_oh;
    logic [IDX_W-1:0]          res_idx;
    logic                      res_sparse;

    function automatic logic [IDX_W:0] lowest_free(input logic [`LD_NUM_DENSE-1:0] free);
        logic [IDX_W:0] sel;
        sel = '0;
        for (int i = `LD_NUM_DENSE - 1; i >= 0; i--) begin
            if (free[i]) sel = {1'b1, IDX_W'(i)};
        end
        return sel;
    endfunction

    // a core finishing this cycle counts as free already
    assign free_d     = ~busy_d | dense_done;
    assign free_s_ext = {{(`LD_NUM_DENSE-`LD_NUM_SPARSE){1'b0}}, ~busy_s | sparse_done};
    assign pick       = pool_sparse ? lowest_free(free_s_ext) : lowest_free(free_d);
    assign take       = core_req && !grant && pick[IDX_W];
    assign pick_oh    = {{(`LD_NUM_DENSE-1){1'b0}}, take} << pick[IDX_W-1:0];
    assign res_oh     = {{(`LD_NUM_DENSE-1){1'b0}}, 1'b1} << res_idx;

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            busy_d       <= '0;
            busy_s       <= '0;
            grant        <= 1'b0;
            res_idx      <= '0;
            res_sparse   <= 1'b0;
            dense_start  <= '0;
            sparse_start <= '0;
        end else begin
            busy_d <= (busy_d & ~dense_done) | (pool_sparse ? '0 : pick_oh);
            busy_s <= (busy_s & ~sparse_done) |
                      (pool_sparse ? pick_oh[`LD_NUM_SPARSE-1:0] : '0);
            grant  <= take;
            if (take) begin
                res_idx    <= pick[IDX_W-1:0];
                res_sparse <= pool_sparse;
            end
            dense_start  <= (launch && !res_sparse) ? res_oh : '0;
            sparse_start <= (launch && res_sparse) ? res_oh[`LD_NUM_SPARSE-1:0] : '0;
        end
    end

    assert property (@(posedge clk) disable iff (!resetn)
        ((dense_start & ~busy_d) == '0) && ((sparse_start & ~busy_s) == '0))
        else $error("core_pool: start sent to a core that was not reserved");

endmodule

// File: hdl/weight_streamer.sv
`include "loader_macros.svh"

module weight_streamer import loader_pkg::*; (
    input  logic                  clk,
    input  logic                  resetn,
    input  layer_cfg_t            cfg,
    input  logic [`LD_IC_W-1:0]   ic_idx,
    input  logic                  load_go,
    output mem_rd_t               weight_rd,
    output row_wr_t               weight_wr,
    output logic                  load_done,
    input  logic [`LD_DATA_W-1:0] weight_rdata
);

    logic [3:0]                kk;            // taps per filter
    logic [`LD_ADDR_W-1:0]     kk_ic;         // stride between filters
    logic [`LD_WGT_ROW_AW:0]   row_words;
    logic [`LD_ADDR_W-1:0]     ch_off;
    logic [`LD_ADDR_W-1:0]     filt_base;
    logic [`LD_ADDR_W-1:0]     w_addr;
    logic [`LD_DIM_W-1:0]      filt;
    logic [3:0]                tap;
    logic [`LD_WGT_ROW_AW-1:0] row_idx;
    logic [`LD_WGT_ROW_AW-1:0] wr_idx_q;
    logic                      active;
    logic                      rd_vld_q;
    logic                      last_q;
    logic                      last_tap;
    logic                      last_word;

    assign kk        = cfg.k * cfg.k;
    assign kk_ic     = kk * cfg.total_ic;
    assign row_words = kk * cfg.oc;
    assign last_tap  = (tap == kk - 1'b1);
    assign last_word = last_tap && (filt == cfg.oc - 1'b1);
    assign w_addr    = filt_base + ch_off + tap;   // filter-major

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            active  <= 1'b0;
            filt    <= '0;
            tap     <= '0;
            row_idx <= '0;
        end else if (load_go) begin
            active  <= 1'b1;
            filt    <= '0;
            tap     <= '0;
            row_idx <= '0;
        end else if (active) begin
            row_idx <= row_idx + 1'b1;
            if (last_tap) begin
                tap  <= '0;
                filt <= filt + 1'b1;
            end else begin
                tap <= tap + 1'b1;
            end
            if (last_word) active <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (load_go) begin
            ch_off    <= ic_idx * kk;
            filt_base <= '0;
        end else if (active && last_tap) begin
            filt_base <= filt_base + kk_ic;   // next output channel
        end
        wr_idx_q <= row_idx;
    end

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            rd_vld_q <= 1'b0;
            last_q   <= 1'b0;
        end else begin
            rd_vld_q <= active;
            last_q   <= active && last_word;
        end
    end

    assign load_done = last_q;

    always_comb begin
        weight_rd.en   = active;
        weight_rd.addr = {{(`LD_ADDR_IN-`LD_ADDR_W){1'b0}}, w_addr};
        weight_wr.en   = rd_vld_q;
        weight_wr.addr = {{(`LD_ACT_ROW_AW-`LD_WGT_ROW_AW){1'b0}}, wr_idx_q};
        weight_wr.data = weight_rdata;
    end

    assert property (@(posedge clk) disable iff (!resetn)
        weight_wr.en |-> weight_wr.addr < row_words)
        else $error("weight_streamer: row write past K*K*OC");

endmodule

// File: hdl/act_streamer.sv
`include "loader_macros.svh"

module act_streamer import loader_pkg::*; (
    input  logic                  clk,
    input  logic                  resetn,
    input  layer_cfg_t            cfg,
    input  logic [`LD_IC_W-1:0]   ic_idx,
    input  logic                  probe_go,
    input  logic                  load_go,
    output mem_rd_t               act_rd,
    output row_wr_t               act_wr,
    output logic                  probe_done,
    output logic                  is_sparse,
    output logic                  load_done,
    input  logic [`LD_DATA_W-1:0] act_rdata
);

    logic [`LD_DIM_W:0]        hp;            // padded height
    logic [`LD_DIM_W:0]        wp;            // padded width
    logic [`LD_ADDR_IN-1:0]    plane_words;
    logic [`LD_ADDR_IN-1:0]    job_last;
    logic [`LD_ADDR_IN-1:0]    base;
    logic [`LD_ADDR_IN-1:0]    offset;
    logic                      active;
    logic                      load_mode;     // 0 while probing the first row
    logic                      rd_vld_q;
    logic                      last_q;
    logic                      load_q;
    logic [`LD_ACT_ROW_AW-1:0] wr_idx_q;
    logic [`LD_DIM_W:0]        zero_cnt;
    logic [`LD_DIM_W:0]        zeros_total;

    assign hp          = cfg.img_h + cfg.k - 1'b1;
    assign wp          = cfg.img_w + cfg.k - 1'b1;
    assign plane_words = hp * wp;
    assign job_last    = load_mode ? plane_words - 1'b1 : wp - 1'b1;

    // --------------------------------------------------
    // read side
    // --------------------------------------------------
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            active    <= 1'b0;
            load_mode <= 1'b0;
            offset    <= '0;
        end else if (probe_go || load_go) begin
            active    <= 1'b1;
            load_mode <= load_go;
            offset    <= '0;
        end else if (active) begin
            offset <= offset + 1'b1;
            if (offset == job_last) active <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (probe_go || load_go) base <= ic_idx * plane_words;   // channel-major plane
        wr_idx_q <= offset[`LD_ACT_ROW_AW-1:0];
    end

    // --------------------------------------------------
    // return side, one cycle behind the reads
    // --------------------------------------------------
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            rd_vld_q <= 1'b0;
            last_q   <= 1'b0;
            load_q   <= 1'b0;
            zero_cnt <= '0;
        end else begin
            rd_vld_q <= active;
            last_q   <= active && (offset == job_last);
            load_q   <= load_mode;
            if (probe_go)
                zero_cnt <= '0;
            else if (rd_vld_q && !load_q && act_rdata == '0)
                zero_cnt <= zero_cnt + 1'b1;
        end
    end

    // last probe word is still on the bus, count it here
    assign zeros_total = zero_cnt + {{`LD_DIM_W{1'b0}}, (act_rdata == '0)};
    assign is_sparse   = {zeros_total, 1'b0} >= {1'b0, wp};   // 50 % threshold
    assign probe_done  = last_q && !load_q;
    assign load_done   = last_q && load_q;

    always_comb begin
        act_rd.en   = active;
        act_rd.addr = base + offset;
        act_wr.en   = rd_vld_q && load_q;
        act_wr.addr = wr_idx_q;
        act_wr.data = act_rdata;
    end

    assert property (@(posedge clk) disable iff (!resetn) !(probe_go && load_go))
        else $error("act_streamer: probe_go and load_go in the same cycle");

    // sequencer only starts a new job once the previous one has drained
    assert property (@(posedge clk) disable iff (!resetn) active |-> !(probe_go || load_go))
        else $error("act_streamer: job request while a job is running");

endmodule

// File: hdl/loader_pkg.sv
`include "loader_macros.svh"

package loader_pkg;

    // --------------------------------------------------
    // layer shape, stable from start until done
    // --------------------------------------------------
    typedef struct packed {
        logic [`LD_IC_W-1:0]  total_ic;
        logic [`LD_DIM_W-1:0] oc;
        logic [`LD_DIM_W-1:0] img_h;
        logic [`LD_DIM_W-1:0] img_w;
        logic [`LD_K_W-1:0]   k;        // 1 or 3
    } layer_cfg_t;

    // read request to a global memory
    typedef struct packed {
        logic                   en;
        logic [`LD_ADDR_IN-1:0] addr;   // weight port uses the low bits only
    } mem_rd_t;

    // write into a row memory
    typedef struct packed {
        logic                      en;
        logic [`LD_ACT_ROW_AW-1:0] addr;
        logic [`LD_DATA_W-1:0]     data;
    } row_wr_t;

endpackage

// File: hdl/loader_macros.svh
`ifndef LOADER_MACROS_SVH
`define LOADER_MACROS_SVH

// global memory ports
`define LD_ADDR_IN      20
`define LD_ADDR_W       18
`define LD_DATA_W       8

// per-core row memories
`define LD_ACT_ROW_AW   11
`define LD_WGT_ROW_AW   9

// core pools
`define LD_NUM_DENSE    8
`define LD_NUM_SPARSE   4   // must not exceed the dense count

// layer configuration field widths
`define LD_IC_W         10
`define LD_DIM_W        6
`define LD_K_W          3

`endif
